// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

    parameter int XLEN = 64;

    // Major opcodes, instr[6:0].
    typedef enum logic [6:0] {
        F7_ALUI   = 7'b0010011,
        F7_ALU    = 7'b0110011,
        F7_ALUIW  = 7'b0011011,
        F7_ALUW   = 7'b0111011,
        F7_LUI    = 7'b0110111,
        F7_JAL    = 7'b1101111,
        F7_BRANCH = 7'b1100011,
        F7_LD     = 7'b0000011,
        F7_SD     = 7'b0100011,
        F7_AUIPC  = 7'b0010111,
        F7_JALR   = 7'b1100111
    } opcode_t;

    // funct7 values of register-register ops.
    parameter logic [6:0] F7_FIRST_ADD = 7'b0000000;
    parameter logic [6:0] F7_FIRST_SUB = 7'b0100000;
    parameter logic [6:0] F7_FIRST_MUL = 7'b0000001;

    typedef enum logic [3:0] {
        ALUI,
        ALU,
        ALUIW,
        ALUW,
        LUI,
        JAL,
        BR_SET,     // Taken when the ALU flag is set.
        BR_CLR,     // Taken when the ALU flag is clear.
        LD,
        SD,
        AUIPC,
        JALR
    } decode_op_t;

    typedef enum logic [4:0] {
        ADD,
        SUB,
        XOR,
        OR,
        AND,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        MULT,
        DIV,
        DIVU,
        REM,
        REMU,
        CPYB,       // Passes operand b.
        COMPARE     // 1 when a == b.
    } alufunc_t;

endpackage

`default_nettype wire

// File: design/dec_if.sv
`default_nettype none

interface dec_if #(
    parameter int XLEN = rv_pkg::XLEN
) ();

    logic                valid;
    logic                ready;
    rv_pkg::decode_op_t  op;
    rv_pkg::alufunc_t    alufunc;
    logic                regwrite;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [XLEN-1:0]     imm;
    logic [XLEN-1:0]     pc;

    modport source (
        output valid, op, alufunc, regwrite, rs1, rs2, rd, imm, pc,
        input  ready
    );

    modport sink (
        input  valid, op, alufunc, regwrite, rs1, rs2, rd, imm, pc,
        output ready
    );

endinterface

`default_nettype wire

// File: design/decoder.sv
`default_nettype none

module decoder (
    input  logic [31:0]        instr,
    output rv_pkg::decode_op_t op,
    output rv_pkg::alufunc_t   alufunc,
    output logic               regwrite
);

    logic [2:0] funct3;
    logic [6:0] f7_first;

    assign funct3   = instr[14:12];
    assign f7_first = instr[31:25];

    // Immediate forms; bit 30 picks the arithmetic right shift.
    function automatic rv_pkg::alufunc_t imm_func(input logic [2:0] f3, input logic bit30);
        rv_pkg::alufunc_t f;
        case (f3)
            3'b000:  f = rv_pkg::ADD;
            3'b001:  f = rv_pkg::SLL;
            3'b010:  f = rv_pkg::SLT;
            3'b011:  f = rv_pkg::SLTU;
            3'b100:  f = rv_pkg::XOR;
            3'b101:  f = bit30 ? rv_pkg::SRA : rv_pkg::SRL;
            3'b110:  f = rv_pkg::OR;
            default: f = rv_pkg::AND;
        endcase
        return f;
    endfunction

    // Register forms, M extension selected by funct7.
    function automatic rv_pkg::alufunc_t reg_func(input logic [2:0] f3, input logic [6:0] f7);
        rv_pkg::alufunc_t f;
        logic             mul;
        logic             sub;
        mul = (f7 == rv_pkg::F7_FIRST_MUL);
        sub = (f7 == rv_pkg::F7_FIRST_SUB);
        case (f3)
            3'b000: begin
                if (mul)
                    f = rv_pkg::MULT;
                else if (sub)
                    f = rv_pkg::SUB;
                else
                    f = rv_pkg::ADD;
            end
            3'b001:  f = rv_pkg::SLL;
            3'b010:  f = rv_pkg::SLT;
            3'b011:  f = rv_pkg::SLTU;
            3'b100:  f = mul ? rv_pkg::DIV : rv_pkg::XOR;
            3'b101: begin
                if (mul)
                    f = rv_pkg::DIVU;
                else if (sub)
                    f = rv_pkg::SRA;
                else
                    f = rv_pkg::SRL;
            end
            3'b110:  f = mul ? rv_pkg::REM : rv_pkg::OR;
            default: f = mul ? rv_pkg::REMU : rv_pkg::AND;
        endcase
        return f;
    endfunction

    always_comb begin
        op       = rv_pkg::ALUI;
        alufunc  = rv_pkg::ADD;
        regwrite = 1'b1;
        case (instr[6:0])
            rv_pkg::F7_ALU: begin
                op      = rv_pkg::ALU;
                alufunc = reg_func(funct3, f7_first);
            end
            rv_pkg::F7_ALUIW: begin
                op      = rv_pkg::ALUIW;
                alufunc = imm_func(funct3, instr[30]);
            end
            rv_pkg::F7_ALUW: begin
                op      = rv_pkg::ALUW;
                alufunc = reg_func(funct3, f7_first);
            end
            rv_pkg::F7_LUI: begin
                op      = rv_pkg::LUI;
                alufunc = rv_pkg::CPYB;
            end
            rv_pkg::F7_JAL:   op = rv_pkg::JAL;
            rv_pkg::F7_BRANCH: begin
                regwrite = 1'b0;
                // Odd funct3 inverts the sense of the test.
                op = funct3[0] ? rv_pkg::BR_CLR : rv_pkg::BR_SET;
                case (funct3[2:1])
                    2'b10:   alufunc = rv_pkg::SLT;
                    2'b11:   alufunc = rv_pkg::SLTU;
                    default: alufunc = rv_pkg::COMPARE;
                endcase
            end
            rv_pkg::F7_LD:    op = rv_pkg::LD;
            rv_pkg::F7_SD: begin
                op       = rv_pkg::SD;
                regwrite = 1'b0;
            end
            rv_pkg::F7_AUIPC: op = rv_pkg::AUIPC;
            rv_pkg::F7_JALR:  op = rv_pkg::JALR;
            default:          alufunc = imm_func(funct3, instr[30]);  // ALUI and unknown.
        endcase
    end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`default_nettype none

module decode_stage #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [31:0]      in_instr,
    input  logic [XLEN-1:0]  in_pc,
    dec_if.source            dec
);

    rv_pkg::decode_op_t op;
    rv_pkg::alufunc_t   alufunc;
    logic               regwrite;
    logic [XLEN-1:0]    imm;
    logic               ready_en;
    logic               take;

    decoder u_decoder (
        .instr    (in_instr),
        .op       (op),
        .alufunc  (alufunc),
        .regwrite (regwrite)
    );

    always_comb begin
        case (in_instr[6:0])
            rv_pkg::F7_SD:
                imm = {{(XLEN-12){in_instr[31]}}, in_instr[31:25], in_instr[11:7]};
            rv_pkg::F7_BRANCH:
                imm = {{(XLEN-13){in_instr[31]}}, in_instr[31], in_instr[7],
                       in_instr[30:25], in_instr[11:8], 1'b0};
            rv_pkg::F7_LUI, rv_pkg::F7_AUIPC:
                imm = {{(XLEN-32){in_instr[31]}}, in_instr[31:12], 12'b0};
            rv_pkg::F7_JAL:
                imm = {{(XLEN-21){in_instr[31]}}, in_instr[31], in_instr[19:12],
                       in_instr[20], in_instr[30:21], 1'b0};
            default:
                imm = {{(XLEN-12){in_instr[31]}}, in_instr[31:20]};  // I-type.
        endcase
    end

    // Slot is free when empty or being drained this cycle.
    assign in_ready = ready_en && (!dec.valid || dec.ready);
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_en  <= 1'b0;
            dec.valid <= 1'b0;
        end else begin
            ready_en <= 1'b1;   // Opens one clock after reset.
            if (take)
                dec.valid <= 1'b1;
            else if (dec.ready)
                dec.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dec.op       <= op;
            dec.alufunc  <= alufunc;
            dec.regwrite <= regwrite;
            dec.rs1      <= in_instr[19:15];
            dec.rs2      <= in_instr[24:20];
            dec.rd       <= in_instr[11:7];
            dec.imm      <= imm;
            dec.pc       <= in_pc;
        end
    end

endmodule

`default_nettype wire

// File: design/regfile.sv
`default_nettype none

module regfile #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [4:0]       rs1_addr,
    input  logic [4:0]       rs2_addr,
    output logic [XLEN-1:0]  rs1_data,
    output logic [XLEN-1:0]  rs2_data,
    input  logic             we,
    input  logic [4:0]       wa,
    input  logic [XLEN-1:0]  wd
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // x0 reads zero whatever was written there.
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    input  rv_pkg::alufunc_t func,
    input  logic             word,
    output logic [XLEN-1:0]  y
);

    logic [5:0]      shamt;
    logic [XLEN-1:0] a_s, b_s;     // Sign-extended in word mode.
    logic [XLEN-1:0] a_u, b_u;     // Zero-extended in word mode.
    logic            ovf;
    logic [XLEN-1:0] quo_s, rem_s; // Signed quotient and remainder.
    logic [XLEN-1:0] r;

    assign shamt = word ? {1'b0, b[4:0]} : b[5:0];
    assign a_s   = word ? {{(XLEN-32){a[31]}}, a[31:0]} : a;
    assign b_s   = word ? {{(XLEN-32){b[31]}}, b[31:0]} : b;
    assign a_u   = word ? {{(XLEN-32){1'b0}}, a[31:0]} : a;
    assign b_u   = word ? {{(XLEN-32){1'b0}}, b[31:0]} : b;

    // Most negative / -1. Word mode cannot overflow at full width.
    assign ovf = (a_s == {1'b1, {(XLEN-1){1'b0}}}) && (&b_s);

    assign quo_s = $signed(a_s) / $signed(b_s);
    assign rem_s = $signed(a_s) % $signed(b_s);

    always_comb begin
        case (func)
            rv_pkg::ADD:     r = a + b;
            rv_pkg::SUB:     r = a - b;
            rv_pkg::XOR:     r = a ^ b;
            rv_pkg::OR:      r = a | b;
            rv_pkg::AND:     r = a & b;
            rv_pkg::SLT:     r = {{(XLEN-1){1'b0}}, $signed(a_s) < $signed(b_s)};
            rv_pkg::SLTU:    r = {{(XLEN-1){1'b0}}, a_u < b_u};
            rv_pkg::SLL:     r = a << shamt;
            rv_pkg::SRL:     r = a_u >> shamt;
            rv_pkg::SRA:     r = $signed(a_s) >>> shamt;
            rv_pkg::MULT:    r = a * b;
            rv_pkg::DIV:     r = (b_s == '0) ? '1 : ovf ? a_s : quo_s;
            rv_pkg::DIVU:    r = (b_u == '0) ? '1 : a_u / b_u;
            rv_pkg::REM:     r = (b_s == '0) ? a_s : ovf ? '0 : rem_s;
            rv_pkg::REMU:    r = (b_u == '0) ? a_u : a_u % b_u;
            rv_pkg::CPYB:    r = b;
            rv_pkg::COMPARE: r = {{(XLEN-1){1'b0}}, a == b};
            default:         r = '0;
        endcase
    end

    assign y = word ? {{(XLEN-32){r[31]}}, r[31:0]} : r;

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`default_nettype none

module execute_stage #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic               clk,
    input  logic               rst_n,
    dec_if.sink                dec,
    output logic               out_valid,
    input  logic               out_ready,
    output rv_pkg::decode_op_t out_op,
    output logic [4:0]         out_rd,
    output logic [XLEN-1:0]    out_result,
    output logic [XLEN-1:0]    out_store_data,
    output logic               out_taken,
    output logic [XLEN-1:0]    out_target
);

    logic [XLEN-1:0] rs1_data, rs2_data;
    logic [XLEN-1:0] opa, opb, alu_y;
    logic [XLEN-1:0] result, target;
    logic            word, taken, load, we;

    assign dec.ready = !out_valid || out_ready;
    assign load      = dec.valid && dec.ready;
    // Loads leave the core; nothing comes back to write.
    assign we = load && dec.regwrite && (dec.rd != 5'd0) && (dec.op != rv_pkg::LD);

    regfile #(.XLEN(XLEN)) u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (dec.rs1),
        .rs2_addr (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (we),
        .wa       (dec.rd),
        .wd       (result)
    );

    always_comb begin
        case (dec.op)
            rv_pkg::AUIPC: opa = dec.pc;
            rv_pkg::LUI:   opa = '0;
            default:       opa = rs1_data;
        endcase
        case (dec.op)
            rv_pkg::ALU, rv_pkg::ALUW, rv_pkg::BR_SET, rv_pkg::BR_CLR: opb = rs2_data;
            default: opb = dec.imm;
        endcase
    end

    assign word = (dec.op == rv_pkg::ALUIW) || (dec.op == rv_pkg::ALUW);

    alu #(.XLEN(XLEN)) u_alu (
        .a    (opa),
        .b    (opb),
        .func (dec.alufunc),
        .word (word),
        .y    (alu_y)
    );

    always_comb begin
        result = alu_y;
        taken  = 1'b0;
        target = dec.pc + dec.imm;
        case (dec.op)
            rv_pkg::JAL: begin
                result = dec.pc + XLEN'(4);
                taken  = 1'b1;
            end
            rv_pkg::JALR: begin
                result = dec.pc + XLEN'(4);
                taken  = 1'b1;
                target = {alu_y[XLEN-1:1], 1'b0};   // rs1 + imm, bit 0 cleared.
            end
            rv_pkg::BR_SET: taken = |alu_y;
            rv_pkg::BR_CLR: taken = ~|alu_y;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (dec.ready)
            out_valid <= dec.valid;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_op         <= dec.op;
            out_rd         <= dec.rd;
            out_result     <= result;
            out_store_data <= rs2_data;
            out_taken      <= taken;
            out_target     <= target;
        end
    end

endmodule

`default_nettype wire

// File: design/rv_exec.sv
`default_nettype none

module rv_exec #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  logic [31:0]        in_instr,
    input  logic [XLEN-1:0]    in_pc,
    output logic               out_valid,
    input  logic               out_ready,
    output rv_pkg::decode_op_t out_op,
    output logic [4:0]         out_rd,
    output logic [XLEN-1:0]    out_result,
    output logic [XLEN-1:0]    out_store_data,
    output logic               out_taken,
    output logic [XLEN-1:0]    out_target
);

    dec_if #(.XLEN(XLEN)) dec ();

    decode_stage #(.XLEN(XLEN)) u_decode_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .dec      (dec.source)
    );

    execute_stage #(.XLEN(XLEN)) u_execute_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .dec            (dec.sink),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_op         (out_op),
        .out_rd         (out_rd),
        .out_result     (out_result),
        .out_store_data (out_store_data),
        .out_taken      (out_taken),
        .out_target     (out_target)
    );

endmodule

`default_nettype wire

// File: dv/rv_exec_tb_table.svh
`ifndef RV_EXEC_TB_TABLE_SVH
`define RV_EXEC_TB_TABLE_SVH

    // Each row gives the instruction, the expected op and rd, then the result and either
    // the store data or the taken flag and target. The pc starts at 0x1000 and steps by 4.
    task automatic build_table();
        expect_reg(i_type(5, 0, 0, 1, rv_pkg::F7_ALUI), rv_pkg::ALUI, 1, 64'h5);
        expect_reg(i_type(-3, 0, 0, 2, rv_pkg::F7_ALUI), rv_pkg::ALUI, 2, 64'hFFFFFFFF_FFFFFFFD);
        expect_reg(u_type('h12345, 3, rv_pkg::F7_LUI), rv_pkg::LUI, 3, 64'h12345000);
        expect_reg(u_type(1, 4, rv_pkg::F7_AUIPC), rv_pkg::AUIPC, 4, 64'h200C);
        expect_reg(r_type(0, 2, 1, 0, 5, rv_pkg::F7_ALU), rv_pkg::ALU, 5, 64'h2);
        expect_reg(r_type(32, 2, 1, 0, 6, rv_pkg::F7_ALU), rv_pkg::ALU, 6, 64'h8);
        expect_reg(r_type(0, 2, 1, 4, 7, rv_pkg::F7_ALU), rv_pkg::ALU, 7, 64'hFFFFFFFF_FFFFFFF8);
        expect_reg(r_type(0, 1, 2, 2, 8, rv_pkg::F7_ALU), rv_pkg::ALU, 8, 64'h1);
        expect_reg(r_type(0, 1, 2, 3, 9, rv_pkg::F7_ALU), rv_pkg::ALU, 9, 64'h0);
        expect_reg(r_type(0, 6, 1, 1, 10, rv_pkg::F7_ALU), rv_pkg::ALU, 10, 64'h500);
        expect_reg(r_type(32, 1, 2, 5, 11, rv_pkg::F7_ALU), rv_pkg::ALU, 11, 64'hFFFFFFFF_FFFFFFFF);
        expect_reg(r_type(0, 1, 3, 5, 12, rv_pkg::F7_ALU), rv_pkg::ALU, 12, 64'h91A280);
        // Word forms wrap past 32 bits.
        expect_reg(u_type('h80000, 14, rv_pkg::F7_LUI), rv_pkg::LUI, 14, 64'hFFFFFFFF_80000000);
        expect_reg(i_type(-1, 14, 0, 13, rv_pkg::F7_ALUIW), rv_pkg::ALUIW, 13, 64'h7FFFFFFF);
        expect_reg(i_type(29, 0, 0, 15, rv_pkg::F7_ALUI), rv_pkg::ALUI, 15, 64'h1D);
        expect_reg(r_type(0, 15, 1, 1, 16, rv_pkg::F7_ALUW), rv_pkg::ALUW, 16, 64'hFFFFFFFF_A0000000);
        expect_reg(r_type(32, 1, 14, 0, 17, rv_pkg::F7_ALUW), rv_pkg::ALUW, 17, 64'h7FFFFFFB);
        // Multiply and divide, with zero divisors and the overflow case.
        expect_reg(r_type(1, 6, 2, 0, 18, rv_pkg::F7_ALU), rv_pkg::ALU, 18, 64'hFFFFFFFF_FFFFFFE8);
        expect_reg(r_type(1, 2, 6, 4, 19, rv_pkg::F7_ALU), rv_pkg::ALU, 19, 64'hFFFFFFFF_FFFFFFFE);
        expect_reg(r_type(1, 0, 6, 5, 20, rv_pkg::F7_ALU), rv_pkg::ALU, 20, 64'hFFFFFFFF_FFFFFFFF);
        expect_reg(r_type(1, 2, 6, 6, 21, rv_pkg::F7_ALU), rv_pkg::ALU, 21, 64'h2);
        expect_reg(r_type(1, 0, 6, 7, 22, rv_pkg::F7_ALU), rv_pkg::ALU, 22, 64'h8);
        expect_reg(i_type(1, 0, 0, 23, rv_pkg::F7_ALUI), rv_pkg::ALUI, 23, 64'h1);
        expect_reg(i_type(63, 23, 1, 23, rv_pkg::F7_ALUI), rv_pkg::ALUI, 23, 64'h80000000_00000000);
        expect_reg(r_type(1, 11, 23, 4, 24, rv_pkg::F7_ALU), rv_pkg::ALU, 24, 64'h80000000_00000000);
        expect_reg(r_type(1, 11, 23, 6, 25, rv_pkg::F7_ALU), rv_pkg::ALU, 25, 64'h0);
        // Branches on x1 = 5 and x2 = -3.
        expect_branch(b_type(16, 1, 1, 0), rv_pkg::BR_SET, 1'b1, 64'h1078);
        expect_branch(b_type(-8, 2, 1, 1), rv_pkg::BR_CLR, 1'b1, 64'h1064);
        expect_branch(b_type(8, 2, 1, 4), rv_pkg::BR_SET, 1'b0, 64'h1078);
        expect_branch(b_type(12, 1, 2, 5), rv_pkg::BR_CLR, 1'b0, 64'h1080);
        expect_branch(b_type(4, 2, 1, 6), rv_pkg::BR_SET, 1'b1, 64'h107C);
        expect_branch(b_type(-4, 2, 1, 7), rv_pkg::BR_CLR, 1'b0, 64'h1078);
        expect_branch(b_type(32, 2, 1, 5), rv_pkg::BR_CLR, 1'b1, 64'h10A0);
        expect_jump(j_type('h100, 26), rv_pkg::JAL, 26, 64'h1088, 64'h1184);
        expect_jump(i_type('h21, 3, 0, 27, rv_pkg::F7_JALR), rv_pkg::JALR, 27, 64'h108C,
                    64'h12345020);
        // Loads and stores, then x28 must still read zero.
        expect_mem(i_type(16, 3, 3, 28, rv_pkg::F7_LD), rv_pkg::LD, 28, 64'h12345010, 64'h0);
        expect_mem(s_type(-8, 6, 3), rv_pkg::SD, 0, 64'h12344FF8, 64'h8);
        expect_reg(r_type(0, 1, 28, 0, 29, rv_pkg::F7_ALU), rv_pkg::ALU, 29, 64'h5);
        expect_reg(i_type(7, 1, 0, 0, rv_pkg::F7_ALUI), rv_pkg::ALUI, 0, 64'hC);
        expect_reg(r_type(0, 1, 0, 0, 30, rv_pkg::F7_ALU), rv_pkg::ALU, 30, 64'h5);
        // Signed divide and remainder by zero.
        expect_reg(r_type(1, 0, 6, 4, 31, rv_pkg::F7_ALU), rv_pkg::ALU, 31, 64'hFFFFFFFF_FFFFFFFF);
        expect_reg(r_type(1, 0, 6, 6, 31, rv_pkg::F7_ALU), rv_pkg::ALU, 31, 64'h8);
    endtask

`endif

// File: dv/rv_exec_tb.sv
`default_nettype none

module rv_exec_tb;

    localparam int          XLEN    = rv_pkg::XLEN;
    localparam logic [31:0] SEED    = 32'h346c475e;
    localparam logic [63:0] PC_BASE = 64'h1000;

    typedef struct packed {
        logic [31:0]        instr;
        logic [XLEN-1:0]    pc;
        rv_pkg::decode_op_t op;
        logic [4:0]         rd;
        logic [XLEN-1:0]    result;
        logic [XLEN-1:0]    sdata;
        logic               taken;
        logic [XLEN-1:0]    target;
    } row_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    logic [31:0]        in_instr;
    logic [XLEN-1:0]    in_pc;
    logic               out_valid;
    logic               out_ready;
    rv_pkg::decode_op_t out_op;
    logic [4:0]         out_rd;
    logic [XLEN-1:0]    out_result;
    logic [XLEN-1:0]    out_store_data;
    logic               out_taken;
    logic [XLEN-1:0]    out_target;

    row_t        rows[$];
    row_t        held;        // Outputs seen while stalled.
    logic        stalled;
    logic [31:0] lfsr;
    int          got;
    int          cur_row;
    int          cycles;
    int          limit;
    int          mismatches;
    int          other_errors;

    rv_exec #(.XLEN(XLEN)) rv_exec_i (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    // Instruction encoders take their arguments in the order of the bit layout.
    function automatic logic [31:0] r_type(input int f7, rs2, rs1, f3, rd, input logic [6:0] opc);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] i_type(input int imm, rs1, f3, rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int imm, rs2, rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], rv_pkg::F7_SD};
    endfunction

    function automatic logic [31:0] b_type(input int imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                rv_pkg::F7_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input int imm, rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] j_type(input int imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::F7_JAL};
    endfunction

    // Galois LFSR with the taps of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic is_branch(input rv_pkg::decode_op_t op);
        return (op == rv_pkg::BR_SET) || (op == rv_pkg::BR_CLR);
    endfunction

    task automatic add_row(input logic [31:0] instr, input rv_pkg::decode_op_t op, input int rd,
                           input logic [XLEN-1:0] result, sdata, input logic taken,
                           input logic [XLEN-1:0] target);
        row_t r;
        r.instr  = instr;
        r.pc     = PC_BASE + XLEN'(4 * rows.size());
        r.op     = op;
        r.rd     = rd[4:0];
        r.result = result;
        r.sdata  = sdata;
        r.taken  = taken;
        r.target = target;
        rows.push_back(r);
    endtask

    task automatic expect_reg(input logic [31:0] instr, input rv_pkg::decode_op_t op,
                              input int rd, input logic [XLEN-1:0] result);
        add_row(instr, op, rd, result, '0, 1'b0, '0);
    endtask

    task automatic expect_branch(input logic [31:0] instr, input rv_pkg::decode_op_t op,
                                 input logic taken, input logic [XLEN-1:0] target);
        add_row(instr, op, 0, '0, '0, taken, target);
    endtask

    task automatic expect_jump(input logic [31:0] instr, input rv_pkg::decode_op_t op,
                               input int rd, input logic [XLEN-1:0] result, target);
        add_row(instr, op, rd, result, '0, 1'b1, target);
    endtask

    task automatic expect_mem(input logic [31:0] instr, input rv_pkg::decode_op_t op,
                              input int rd, input logic [XLEN-1:0] result, sdata);
        add_row(instr, op, rd, result, sdata, 1'b0, '0);
    endtask

    `include "rv_exec_tb_table.svh"

    task automatic compare(input string name, input logic [XLEN-1:0] got_v, exp_v);
        if (got_v !== exp_v) begin
            mismatches++;
            $display("Mismatch %s row %0d: got %h, expected %h", name, cur_row, got_v, exp_v);
        end
    endtask

    // Fields that the op leaves undefined are skipped unless all are asked for.
    task automatic check_outputs(input row_t r, input logic all_fields);
        logic br;
        br = is_branch(r.op);
        compare("out_op", XLEN'(out_op), XLEN'(r.op));
        compare("out_taken", XLEN'(out_taken), XLEN'(r.taken));
        if (all_fields || !(br || r.op == rv_pkg::SD))
            compare("out_rd", XLEN'(out_rd), XLEN'(r.rd));
        if (all_fields || !br)
            compare("out_result", out_result, r.result);
        if (all_fields || r.op == rv_pkg::SD)
            compare("out_store_data", out_store_data, r.sdata);
        if (all_fields || br || r.op == rv_pkg::JAL || r.op == rv_pkg::JALR)
            compare("out_target", out_target, r.target);
    endtask

    task automatic finish_run();
        $display("Collected %0d of %0d results, %0d mismatches, %0d other errors",
                 got, rows.size(), mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0 && got == rows.size())
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    always @(negedge clk) begin
        lfsr      = lfsr_next(lfsr);
        out_ready = lfsr[0];
    end

    // Outputs are sampled at the rising edge, before the DUT updates them.
    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (stalled) begin
                if (!out_valid) begin
                    other_errors++;
                    $display("out_valid dropped at cycle %0d while the output was stalled",
                             cycles);
                end else begin
                    check_outputs(held, 1'b1);
                end
            end
            if (out_valid && out_ready) begin
                if (got < rows.size()) begin
                    cur_row = got;
                    check_outputs(rows[got], 1'b0);
                    got++;
                end else begin
                    other_errors++;
                    $display("An extra result came out after the last row at cycle %0d", cycles);
                end
            end
            stalled = out_valid && !out_ready;
            if (stalled) begin
                held.op     = out_op;
                held.rd     = out_rd;
                held.result = out_result;
                held.sdata  = out_store_data;
                held.taken  = out_taken;
                held.target = out_target;
            end
            if (cycles >= limit) begin
                other_errors++;
                $display("Timeout after %0d cycles with %0d results still missing",
                         cycles, rows.size() - got);
                finish_run();
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_instr     = '0;
        in_pc        = '0;
        out_ready    = 1'b0;
        lfsr         = SEED;
        stalled      = 1'b0;
        got          = 0;
        cur_row      = 0;
        cycles       = 0;
        mismatches   = 0;
        other_errors = 0;
        build_table();
        limit = 20 * rows.size() + 100;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        foreach (rows[i]) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_instr = rows[i].instr;
            in_pc    = rows[i].pc;
            @(posedge clk);
            while (!in_ready)
                @(posedge clk);   // Leaves on the accepting edge.
        end
        @(negedge clk);
        in_valid = 1'b0;
        wait (got == rows.size());
        repeat (4) @(posedge clk);
        finish_run();
    end

endmodule

`default_nettype wire

// File: rv_exec.f
+incdir+dv
design/rv_pkg.sv
design/dec_if.sv
design/decoder.sv
design/decode_stage.sv
design/regfile.sv
design/alu.sv
design/execute_stage.sv
design/rv_exec.sv
dv/rv_exec_tb.sv

// File: Makefile
SIM      = verilator
TOP      = rv_exec_tb
FILELIST = rv_exec.f
BUILD    = obj_dir
FLAGS    = --binary --timing -j 0 --top-module $(TOP) -Mdir $(BUILD)
LOG      = sim.log
PASS     = Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
